// File: sources.f
logic/axis2axi_pkg.sv
logic/axis2axi_ram_2p.sv
logic/axis2axi_fifo.sv
logic/axis2axi_in.sv
logic/axis2axi_top.sv
tests/axis2axi_chk.sv
tests/axis2axi_tb.sv

// File: Bender.yml
package:
  name: axis2axi

sources:
  - files:
      - logic/axis2axi_pkg.sv
      - logic/axis2axi_ram_2p.sv
      - logic/axis2axi_fifo.sv
      - logic/axis2axi_in.sv
      - logic/axis2axi_top.sv
  - target: test
    files:
      - tests/axis2axi_chk.sv
      - tests/axis2axi_tb.sv

// File: tests/axis2axi_tb.sv
`timescale 1ns/1ns
`default_nettype none

module axis2axi_tb import axis2axi_pkg::*; ();

   localparam int unsigned BURST_W        = 4;
   localparam int unsigned BURST_WORDS    = 2 ** BURST_W;
   localparam int unsigned BUF_WORDS      = 2 ** (BURST_W + 1);
   localparam logic [31:0] SEED           = 32'd45;
   localparam int unsigned N_MAIN         = 300;
   localparam int unsigned N_SPLIT        = 20;
   localparam int unsigned N_TAIL         = 5;
   localparam int unsigned N_NEXT         = 3;
   localparam int unsigned N_STALL        = 120;
   localparam int unsigned TOTAL_WORDS    = N_MAIN + N_SPLIT + N_TAIL + N_NEXT + N_STALL;
   localparam int unsigned TIMEOUT_CYCLES = 200 * TOTAL_WORDS + 2000;

   logic  clk = 1'b0;
   logic  rst_n;
   addr_t cfg_addr;
   logic  cfg_valid;
   logic  cfg_ready;
   data_t s_data;
   logic  s_valid;
   logic  s_ready;
   aw_t   m_aw;
   logic  m_awvalid;
   logic  m_awready;
   w_t    m_w;
   logic  m_wvalid;
   logic  m_wready;
   logic  m_bvalid;

   int unsigned error_count;
   int unsigned check_count;
   logic [31:0] rng_stream;
   logic [31:0] rng_slave;
   data_t       mem_model [addr_t];
   data_t       sent_q [$];
   addr_t       next_addr;
   addr_t       cur_addr;
   int unsigned cur_len;
   int unsigned beat_idx;
   int unsigned beats_written;
   int unsigned first_len;
   logic        first_open;
   logic        stall_mode;
   logic        saw_full;
   int unsigned aw_hold;
   int unsigned w_hold;
   logic        b_pending;
   int unsigned b_delay;

   axis2axi_top #(
      .BURST_W (BURST_W)
   ) DUT (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .cfg_addr_i  (cfg_addr),
      .cfg_valid_i (cfg_valid),
      .cfg_ready_o (cfg_ready),
      .s_data_i    (s_data),
      .s_valid_i   (s_valid),
      .s_ready_o   (s_ready),
      .m_aw_o      (m_aw),
      .m_awvalid_o (m_awvalid),
      .m_awready_i (m_awready),
      .m_w_o       (m_w),
      .m_wvalid_o  (m_wvalid),
      .m_wready_i  (m_wready),
      .m_bvalid_i  (m_bvalid)
   );

   bind axis2axi_top axis2axi_chk u_chk (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .aw_i      (m_aw_o),
      .awvalid_i (m_awvalid_o),
      .awready_i (m_awready_i),
      .w_i       (m_w_o),
      .wvalid_i  (m_wvalid_o),
      .wready_i  (m_wready_i)
   );

   initial begin
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // Upper bits only, the low LCG bits cycle too fast
   function automatic int unsigned draw(input logic [31:0] state, input int unsigned range);
      return int'(state[31:16]) % range;
   endfunction

   task automatic check_equal(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      check_count++;
      if (expected !== actual) begin
         error_count++;
         $display("ERR %s expected 0x%0h actual 0x%0h", name, expected, actual);
      end
   endtask

   // Ready pattern of one AXI channel
   task automatic next_ready(inout int unsigned hold, output logic ready);
      rng_slave = lcg_next(rng_slave);
      if (hold > 0) begin
         hold--;
         ready = 1'b0;
      end else if (stall_mode && draw(rng_slave, 3) == 0) begin
         hold  = 40 + draw(lcg_next(rng_slave), 24);
         ready = 1'b0;
      end else begin
         ready = stall_mode || (draw(rng_slave, 4) != 0);
      end
   endtask

   task automatic record_burst(input aw_t aw);
      int unsigned beats;
      int unsigned offset;
      beats  = int'(aw.len) + 1;
      offset = aw.addr[11:0];
      check_equal("burst_len_max", 1, beats <= BURST_WORDS);
      check_equal("burst_in_page", 1, (offset + 4 * beats) <= 4096);
      check_equal("burst_addr", next_addr, aw.addr);
      if (first_open) begin
         first_len  = beats;
         first_open = 1'b0;
      end
      next_addr = aw.addr + addr_t'(4 * beats);
      cur_addr  = aw.addr;
      cur_len   = aw.len;
      beat_idx  = 0;
   endtask

   task automatic store_beat(input w_t w);
      check_equal("beat_in_burst", 1, beat_idx <= cur_len);
      check_equal("wlast", beat_idx == cur_len, w.last);
      mem_model[cur_addr + addr_t'(4 * beat_idx)] = w.data;
      beats_written++;
      beat_idx++;
      if (w.last) begin
         rng_slave = lcg_next(rng_slave);
         b_pending = 1'b1;
         b_delay   = draw(rng_slave, 6);
      end
   endtask

   // AXI slave, handshakes complete on the next rising edge
   always @(negedge clk) begin
      m_bvalid = 1'b0;
      if (b_pending) begin
         if (b_delay == 0) begin
            m_bvalid  = 1'b1;
            b_pending = 1'b0;
         end else begin
            b_delay--;
         end
      end
      next_ready(aw_hold, m_awready);
      next_ready(w_hold, m_wready);
      if (m_awvalid && m_awready) begin
         record_burst(m_aw);
      end
      if (m_wvalid && m_wready) begin
         store_beat(m_w);
      end
   end

   task automatic configure(input addr_t addr);
      @(negedge clk);
      while (!cfg_ready) begin
         @(negedge clk);
      end
      cfg_addr      = addr;
      cfg_valid     = 1'b1;
      next_addr     = addr;
      first_open    = 1'b1;
      beats_written = 0;
      sent_q.delete();
      @(negedge clk);
      cfg_valid = 1'b0;
   endtask

   // Gap chance is one in gap_div, none when zero
   task automatic send_stream(input int unsigned n, input int unsigned gap_div);
      int unsigned sent;
      sent = 0;
      while (sent < n) begin
         @(negedge clk);
         rng_stream = lcg_next(rng_stream);
         if (!s_ready) begin
            saw_full = 1'b1;
            check_equal("full_level", 1, (sent - beats_written) >= BUF_WORDS);
         end
         if (s_ready && (gap_div == 0 || draw(rng_stream, gap_div) != 0)) begin
            rng_stream = lcg_next(rng_stream);
            s_data     = rng_stream;
            s_valid    = 1'b1;
            sent_q.push_back(rng_stream);
            sent++;
         end else begin
            s_valid = 1'b0;
         end
      end
      @(negedge clk);
      s_valid = 1'b0;
   endtask

   // Idle once every word is written and the response is back
   task automatic wait_idle(input int unsigned n);
      do begin
         @(negedge clk);
      end while (!(beats_written >= n && !b_pending));
      // One more cycle for the engine to take the response
      @(negedge clk);
   endtask

   task automatic verify_memory(input string name, input addr_t base);
      addr_t addr;
      for (int i = 0; i < sent_q.size(); i++) begin
         addr = base + addr_t'(4 * i);
         check_equal($sformatf("%s_present_%0d", name, i), 1, mem_model.exists(addr));
         if (mem_model.exists(addr)) begin
            check_equal($sformatf("%s_word_%0d", name, i), sent_q[i], mem_model[addr]);
         end
      end
      check_equal({name, "_beats"}, sent_q.size(), beats_written);
   endtask

   initial begin
      error_count   = 0;
      check_count   = 0;
      rng_stream    = SEED;
      rng_slave     = lcg_next(SEED);
      rst_n         = 1'b0;
      cfg_addr      = '0;
      cfg_valid     = 1'b0;
      s_data        = '0;
      s_valid       = 1'b0;
      m_awready     = 1'b0;
      m_wready      = 1'b0;
      m_bvalid      = 1'b0;
      next_addr     = '0;
      cur_addr      = '0;
      cur_len       = 0;
      beat_idx      = 0;
      beats_written = 0;
      first_len     = 0;
      first_open    = 1'b0;
      stall_mode    = 1'b0;
      saw_full      = 1'b0;
      aw_hold       = 0;
      w_hold        = 0;
      b_pending     = 1'b0;
      b_delay       = 0;
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      check_equal("reset_s_ready", 1, s_ready);
      check_equal("reset_cfg_ready", 1, cfg_ready);
      check_equal("reset_awvalid", 0, m_awvalid);
      check_equal("reset_wvalid", 0, m_wvalid);

      // Long random stream across a page boundary
      configure(32'h0001_0F40);
      send_stream(N_MAIN, 8);
      wait_idle(N_MAIN);
      verify_memory("stream", 32'h0001_0F40);

      // Two words left before the page ends
      configure(32'h0002_1FF8);
      send_stream(N_SPLIT, 0);
      wait_idle(N_SPLIT);
      check_equal("split_first_beats", 2, first_len);
      verify_memory("split", 32'h0002_1FF8);

      // Short stream flushed as one tail burst
      configure(32'h0004_0100);
      send_stream(N_TAIL, 0);
      wait_idle(N_TAIL);
      check_equal("tail_first_beats", N_TAIL, first_len);
      verify_memory("tail", 32'h0004_0100);
      check_equal("tail_cfg_ready", 1, cfg_ready);
      configure(32'h0005_0200);
      send_stream(N_NEXT, 0);
      wait_idle(N_NEXT);
      verify_memory("reconfig", 32'h0005_0200);

      // Long ready stalls fill the buffer
      @(posedge clk);
      stall_mode = 1'b1;
      saw_full   = 1'b0;
      configure(32'h0006_0000);
      send_stream(N_STALL, 0);
      wait_idle(N_STALL);
      verify_memory("stall", 32'h0006_0000);
      check_equal("stall_full_seen", 1, saw_full);

      $display("Summary: %0d checks, %0d errors, %0d assertion failures",
               check_count, error_count, DUT.u_chk.fail_count);
      if (error_count == 0 && DUT.u_chk.fail_count == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Summary: %0d checks, %0d errors, %0d assertion failures",
               check_count, error_count, DUT.u_chk.fail_count);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/axis2axi_chk.sv
`timescale 1ns/1ns
`default_nettype none

module axis2axi_chk import axis2axi_pkg::*; (
   input wire  clk_i,
   input wire  rst_n_i,
   input aw_t  aw_i,
   input wire  awvalid_i,
   input wire  awready_i,
   input w_t   w_i,
   input wire  wvalid_i,
   input wire  wready_i
);

   // Failures seen so far
   int unsigned fail_count = 0;

   // Address request held until accepted
   property aw_hold_p;
      @(posedge clk_i) disable iff (!rst_n_i)
         (awvalid_i && !awready_i) |=> (awvalid_i && $stable(aw_i));
   endproperty

   // Write beat held until accepted
   property w_hold_p;
      @(posedge clk_i) disable iff (!rst_n_i)
         (wvalid_i && !wready_i) |=> (wvalid_i && $stable(w_i));
   endproperty

   // Both valids low right after a reset cycle
   property reset_idle_p;
      @(posedge clk_i) !rst_n_i |=> (!awvalid_i && !wvalid_i);
   endproperty

   aw_hold_a: assert property (aw_hold_p)
      else begin
         fail_count++;
         $error("AW request changed or dropped before awready");
      end

   w_hold_a: assert property (w_hold_p)
      else begin
         fail_count++;
         $error("W beat changed or dropped before wready");
      end

   reset_idle_a: assert property (reset_idle_p)
      else begin
         fail_count++;
         $error("AXI valid high in the cycle after reset");
      end

endmodule

`default_nettype wire

// File: logic/axis2axi_top.sv
`timescale 1ns/1ns
`default_nettype none

module axis2axi_top import axis2axi_pkg::*; #(
   parameter int unsigned BURST_W = 4
) (
   input  wire   clk_i,
   input  wire   rst_n_i,

   // Configuration
   input  addr_t cfg_addr_i,
   input  wire   cfg_valid_i,
   output logic  cfg_ready_o,

   // Stream input
   input  data_t s_data_i,
   input  wire   s_valid_i,
   output logic  s_ready_o,

   // AXI write master
   output aw_t   m_aw_o,
   output logic  m_awvalid_o,
   input  wire   m_awready_i,
   output w_t    m_w_o,
   output logic  m_wvalid_o,
   input  wire   m_wready_i,
   input  wire   m_bvalid_i
);

   // Buffer holds two bursts
   localparam int unsigned BUF_W = BURST_W + 1;

   logic             fifo_full;
   logic             fifo_empty;
   logic [BUF_W:0]   fifo_level;
   data_t            fifo_data;
   logic             fifo_r_en;
   logic             fifo_w_en;

   logic             mem_w_en;
   logic [BUF_W-1:0] mem_w_addr;
   data_t            mem_w_data;
   logic             mem_r_en;
   logic [BUF_W-1:0] mem_r_addr;
   data_t            mem_r_data;

   assign s_ready_o = !fifo_full;
   assign fifo_w_en = s_valid_i && s_ready_o;

   axis2axi_in #(
      .BURST_W (BURST_W)
   ) u_in (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .cfg_addr_i   (cfg_addr_i),
      .cfg_valid_i  (cfg_valid_i),
      .cfg_ready_o  (cfg_ready_o),
      .s_valid_i    (s_valid_i),
      .fifo_level_i (fifo_level),
      .fifo_empty_i (fifo_empty),
      .fifo_data_i  (fifo_data),
      .fifo_r_en_o  (fifo_r_en),
      .m_aw_o       (m_aw_o),
      .m_awvalid_o  (m_awvalid_o),
      .m_awready_i  (m_awready_i),
      .m_w_o        (m_w_o),
      .m_wvalid_o   (m_wvalid_o),
      .m_wready_i   (m_wready_i),
      .m_bvalid_i   (m_bvalid_i)
   );

   axis2axi_fifo #(
      .BUF_W (BUF_W)
   ) u_fifo (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .w_en_i       (fifo_w_en),
      .w_data_i     (s_data_i),
      .w_full_o     (fifo_full),
      .r_en_i       (fifo_r_en),
      .r_data_o     (fifo_data),
      .r_empty_o    (fifo_empty),
      .level_o      (fifo_level),
      .mem_w_en_o   (mem_w_en),
      .mem_w_addr_o (mem_w_addr),
      .mem_w_data_o (mem_w_data),
      .mem_r_en_o   (mem_r_en),
      .mem_r_addr_o (mem_r_addr),
      .mem_r_data_i (mem_r_data)
   );

   axis2axi_ram_2p #(
      .BUF_W (BUF_W)
   ) u_ram (
      .clk_i    (clk_i),
      .w_en_i   (mem_w_en),
      .w_addr_i (mem_w_addr),
      .w_data_i (mem_w_data),
      .r_en_i   (mem_r_en),
      .r_addr_i (mem_r_addr),
      .r_data_o (mem_r_data)
   );

endmodule

`default_nettype wire

// File: logic/axis2axi_in.sv
`timescale 1ns/1ns
`default_nettype none

module axis2axi_in import axis2axi_pkg::*; #(
   parameter int unsigned BURST_W = 4
) (
   input  wire                clk_i,
   input  wire                rst_n_i,

   // Configuration
   input  addr_t              cfg_addr_i,
   input  wire                cfg_valid_i,
   output logic               cfg_ready_o,

   // Stream activity, used for tail flush
   input  wire                s_valid_i,

   // FIFO
   input  wire  [BURST_W+1:0] fifo_level_i,
   input  wire                fifo_empty_i,
   input  data_t              fifo_data_i,
   output logic               fifo_r_en_o,

   // AXI write address
   output aw_t                m_aw_o,
   output logic               m_awvalid_o,
   input  wire                m_awready_i,

   // AXI write data
   output w_t                 m_w_o,
   output logic               m_wvalid_o,
   input  wire                m_wready_i,

   // AXI write response
   input  wire                m_bvalid_i
);

   localparam int unsigned BURST_SIZE = 2 ** BURST_W;

   engine_state_e state_q;
   engine_state_e state_d;

   addr_t              addr_q;
   len_t               len_q;
   len_t               beat_cnt_q;

   logic               full_burst;
   logic               tail_burst;
   logic               start_burst;
   logic [BURST_W:0]   raw_size;
   logic [12:0]        words_left;
   logic [BURST_W:0]   burst_size;
   logic [BURST_W:0]   burst_len;
   logic               beat;
   logic               beat_last;

   // Burst start conditions
   assign full_burst  = (fifo_level_i >= BURST_SIZE);
   assign tail_burst  = (fifo_level_i != '0) && !full_burst && !s_valid_i;
   assign start_burst = (full_burst || tail_burst) && (state_q == WAIT_DATA);

   // Size before the boundary cut
   always_comb begin
      if (full_burst) begin
         raw_size = (BURST_W+1)'(BURST_SIZE);
      end else begin
         raw_size = fifo_level_i[BURST_W:0];
      end
   end

   // Words left up to the next 4 KiB page
   assign words_left = (13'h1000 - {1'b0, addr_q[11:0]}) >> 2;

   always_comb begin
      burst_size = raw_size;
      if (raw_size > words_left) begin
         burst_size = words_left[BURST_W:0];
      end
   end

   assign burst_len = burst_size - 1'b1;

   // Beat handshake
   assign beat      = m_wvalid_o && m_wready_i;
   assign beat_last = (beat_cnt_q == len_q);

   // First read on the start decision, then one per accepted beat
   assign fifo_r_en_o = start_burst || (beat && !beat_last);

   // Outputs decoded from state
   assign m_awvalid_o = (state_q == START_BURST);
   assign m_wvalid_o  = (state_q == TRANSFER);
   assign cfg_ready_o = fifo_empty_i && (state_q == WAIT_DATA);

   assign m_aw_o.addr = addr_q;
   assign m_aw_o.len  = len_q;
   assign m_w_o.data  = fifo_data_i;
   assign m_w_o.last  = beat_last;

   // Next state
   always_comb begin
      state_d = state_q;
      case (state_q)
         WAIT_DATA: begin
            if (start_burst) begin
               state_d = START_BURST;
            end
         end
         START_BURST: begin
            if (m_awready_i) begin
               state_d = TRANSFER;
            end
         end
         TRANSFER: begin
            if (beat && beat_last) begin
               state_d = WAIT_BRESP;
            end
         end
         WAIT_BRESP: begin
            if (m_bvalid_i) begin
               state_d = WAIT_DATA;
            end
         end
         default: begin
            state_d = WAIT_DATA;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= WAIT_DATA;
      end else begin
         state_q <= state_d;
      end
   end

   // Burst length latched with the start decision
   always_ff @(posedge clk_i) begin
      if (start_burst) begin
         len_q <= len_t'(burst_len);
      end
   end

   // Beat counter, cleared while idle
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         beat_cnt_q <= '0;
      end else if (state_q == WAIT_DATA) begin
         beat_cnt_q <= '0;
      end else if (beat) begin
         beat_cnt_q <= beat_cnt_q + 1'b1;
      end
   end

   // Address from configuration or advanced by the finished burst
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         addr_q <= '0;
      end else if (cfg_valid_i && cfg_ready_o) begin
         addr_q <= cfg_addr_i;
      end else if ((state_q == WAIT_BRESP) && m_bvalid_i) begin
         addr_q <= addr_q + ((addr_t'(len_q) + addr_t'(1)) << 2);
      end
   end

endmodule

`default_nettype wire

// File: logic/axis2axi_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module axis2axi_fifo import axis2axi_pkg::*; #(
   parameter int unsigned BUF_W = 5
) (
   input  wire              clk_i,
   input  wire              rst_n_i,

   // Write side
   input  wire              w_en_i,
   input  data_t            w_data_i,
   output logic             w_full_o,

   // Read side
   input  wire              r_en_i,
   output data_t            r_data_o,
   output logic             r_empty_o,

   // Words currently stored
   output logic [BUF_W:0]   level_o,

   // External memory port
   output logic             mem_w_en_o,
   output logic [BUF_W-1:0] mem_w_addr_o,
   output data_t            mem_w_data_o,
   output logic             mem_r_en_o,
   output logic [BUF_W-1:0] mem_r_addr_o,
   input  data_t            mem_r_data_i
);

   localparam logic [BUF_W:0] DEPTH = 1 << BUF_W;

   logic [BUF_W-1:0] w_ptr_q;
   logic [BUF_W-1:0] r_ptr_q;
   logic [BUF_W:0]   level_q;
   logic             wr_ok;
   logic             rd_ok;

   // Flags straight from the level
   assign w_full_o  = (level_q == DEPTH);
   assign r_empty_o = (level_q == '0);
   assign level_o   = level_q;

   // Drop writes when full and reads when empty
   assign wr_ok = w_en_i && !w_full_o;
   assign rd_ok = r_en_i && !r_empty_o;

   // Memory port
   assign mem_w_en_o   = wr_ok;
   assign mem_w_addr_o = w_ptr_q;
   assign mem_w_data_o = w_data_i;
   assign mem_r_en_o   = rd_ok;
   assign mem_r_addr_o = r_ptr_q;

   // RAM output is already registered
   assign r_data_o = mem_r_data_i;

   // Write pointer
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         w_ptr_q <= '0;
      end else if (wr_ok) begin
         w_ptr_q <= w_ptr_q + 1'b1;
      end
   end

   // Read pointer
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         r_ptr_q <= '0;
      end else if (rd_ok) begin
         r_ptr_q <= r_ptr_q + 1'b1;
      end
   end

   // Level moves by one at most per cycle
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         level_q <= '0;
      end else begin
         case ({wr_ok, rd_ok})
            2'b10: begin
               level_q <= level_q + 1'b1;
            end
            2'b01: begin
               level_q <= level_q - 1'b1;
            end
            default: begin
               level_q <= level_q;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/axis2axi_ram_2p.sv
`timescale 1ns/1ns
`default_nettype none

module axis2axi_ram_2p import axis2axi_pkg::*; #(
   parameter int unsigned BUF_W = 5
) (
   input  wire              clk_i,
   input  wire              w_en_i,
   input  wire  [BUF_W-1:0] w_addr_i,
   input  data_t            w_data_i,
   input  wire              r_en_i,
   input  wire  [BUF_W-1:0] r_addr_i,
   output data_t            r_data_o
);

   localparam int unsigned DEPTH = 2 ** BUF_W;

   data_t mem [DEPTH];

   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
      // Read data holds until the next read enable
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

`default_nettype wire

// File: logic/axis2axi_pkg.sv
`default_nettype none

package axis2axi_pkg;

   // AXI widths, only 4-byte beats are supported
   localparam int unsigned ADDR_W = 32;
   localparam int unsigned DATA_W = 32;
   localparam int unsigned LEN_W  = 8;

   // Byte address
   typedef logic [ADDR_W-1:0] addr_t;

   // One stream or AXI data word
   typedef logic [DATA_W-1:0] data_t;

   // AXI length field, beats minus one
   typedef logic [LEN_W-1:0] len_t;

   // Write address request
   typedef struct packed {
      addr_t addr;
      len_t  len;
   } aw_t;

   // One write beat
   typedef struct packed {
      data_t data;
      logic  last;
   } w_t;

   // Write engine states
   typedef enum logic [1:0] {
      WAIT_DATA   = 2'd0,
      START_BURST = 2'd1,
      TRANSFER    = 2'd2,
      WAIT_BRESP  = 2'd3
   } engine_state_e;

endpackage

`default_nettype wire
